/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_soc_periph
BUILD_DIR ?= build
FILELIST  ?= soc_periph.f
VFLAGS    ?= --binary --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf $(BUILD_DIR)

/* common/soc_map_pkg.sv */
package soc_map_pkg;

  // bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int MASK_W = 4;

  // data RAM, 1024 words = 4 KiB
  localparam int RAM_WORDS = 1024;
  localparam int RAM_AW    = $clog2(RAM_WORDS);
  localparam logic [ADDR_W-1:0] RAM_BASE = 32'h0000_0000;
  // lowest address bit compared by the RAM window
  localparam int RAM_SEL_LSB = RAM_AW + 2;

  // UART window, decoded on bits 22 and up
  localparam logic [ADDR_W-1:0] UART_BASE = 32'h0040_0000;
  localparam int UART_SEL_LSB = 22;
  // register offset is mem_addr[4:0]
  localparam int UART_OFFS_W = 5;

  // chip-select vector layout
  localparam int CS_RAM  = 0;
  localparam int CS_UART = 1;
  localparam int NUM_CS  = 2;

endpackage

/* common/uart_pkg.sv */
package uart_pkg;

  // register offsets inside the UART window
  localparam logic [4:0] UART_STATUS = 5'h00;
  localparam logic [4:0] UART_TXDATA = 5'h08;
  localparam logic [4:0] UART_RXDATA = 5'h0C;
  localparam logic [4:0] UART_LED    = 5'h10;

  // status register bits
  localparam int ST_TX_BUSY  = 0;
  localparam int ST_RX_VALID = 1;

  // bit period in clocks, stands in for f_clk / baud
  localparam int CLKS_PER_BIT = 8;
  localparam int BAUD_CNT_W   = $clog2(CLKS_PER_BIT);

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_e;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

endpackage

/* soc_periph.f */
common/soc_map_pkg.sv
common/uart_pkg.sv
verilog/address_decoder.sv
verilog/read_mux.sv
verilog/data_ram.sv
uart/uart_baud_timer.sv
uart/uart_tx_fsm.sv
uart/uart_rx_fsm.sv
uart/peripheral_uart.sv
verilog/soc_periph.sv
tests/tb_soc_periph.sv

/* tests/soc_periph_testdata.txt */
# columns: op addr data mask expected, all hex
# W write, R read, P poll until (status & data) == expected, L led, D idle cycles
R 00400000 00000000 0 00000000
L 00000000 00000000 0 00000000
W 00400010 00000001 1 00000000
L 00000000 00000000 0 00000001
W 00400010 00000000 1 00000000
L 00000000 00000000 0 00000000
W 00000000 DEADBEEF F 00000000
W 00000FFC 01234567 F 00000000
W 00000010 11223344 F 00000000
W 00000010 000000AA 1 00000000
W 00000010 00BB0000 4 00000000
W 00000010 CC00DD00 A 00000000
R 00000010 00000000 0 CCBBDDAA
W 00000FFC 89000000 8 00000000
R 00000FFC 00000000 0 89234567
W 00001FFC FFFFFFFF F 00000000
W 80000000 FFFFFFFF F 00000000
R 00001000 00000000 0 00000000
R 80000000 00000000 0 00000000
R 00000000 00000000 0 DEADBEEF
R 00000FFC 00000000 0 89234567
W 00400008 00000055 1 00000000
P 00400000 00000001 0 00000001
P 00400000 00000001 0 00000000
P 00400000 00000002 0 00000002
R 0040000C 00000000 0 00000055
R 00400000 00000000 0 00000000
W 00400008 00000000 1 00000000
P 00400000 00000001 0 00000000
P 00400000 00000002 0 00000002
R 0040000C 00000000 0 00000000
W 00400008 000000FF 1 00000000
P 00400000 00000001 0 00000000
P 00400000 00000002 0 00000002
R 0040000C 00000000 0 000000FF
R 00400000 00000000 0 00000000
W 00400008 000000A5 1 00000000
W 00400008 0000003C 1 00000000
P 00400000 00000001 0 00000000
P 00400000 00000002 0 00000002
R 0040000C 00000000 0 000000A5
D 00000000 00000064 0 00000000
R 00400000 00000000 0 00000000

/* tests/tb_soc_periph.sv */
module tb_soc_periph
  import soc_map_pkg::*;
  import uart_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam string DATA_FILE = "tests/soc_periph_testdata.txt";
  localparam int SEED = 33679;
  localparam int MAX_LINES = 50;
  // longest line is a poll over one frame of 10 bit periods
  localparam int LINE_CYCLES = 25 * CLKS_PER_BIT;
  localparam int RAND_WORDS = 32;
  // two writes and one read per random word, 4 cycles each at most
  localparam int RAND_CYCLES = 3 * 4 * RAND_WORDS;
  localparam int TIMEOUT_CYCLES = MAX_LINES * LINE_CYCLES + RAND_CYCLES + 500;

  logic              clk;
  logic              rst_n;
  logic [ADDR_W-1:0] mem_addr;
  logic [DATA_W-1:0] mem_wdata;
  logic [MASK_W-1:0] mem_wmask;
  logic              mem_rstrb;
  logic [DATA_W-1:0] mem_rdata;
  logic              txd;
  logic              led;

  int                cycle_cnt;
  int                op_no;
  logic [DATA_W-1:0] model [RAM_WORDS];
  int                rand_idx [$];

  // txd looped back onto rxd
  soc_periph u_dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .mem_addr (mem_addr),
    .mem_wdata(mem_wdata),
    .mem_wmask(mem_wmask),
    .mem_rstrb(mem_rstrb),
    .mem_rdata(mem_rdata),
    .txd      (txd),
    .rxd      (txd),
    .led      (led)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: no progress after %0d cycles, stuck at operation %0d",
               cycle_cnt, op_no);
      $display("TEST FAILED");
      $fatal(1, "simulation timed out");
    end
  end

  task automatic check(input string name, input logic [DATA_W-1:0] actual,
                       input logic [DATA_W-1:0] expected);
    if (actual !== expected) begin
      $display("Error: %s at operation %0d is 0x%08h, expected 0x%08h",
               name, op_no, actual, expected);
      $display("TEST FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // one write cycle, inputs change 1 ns after the edge
  task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                           input logic [MASK_W-1:0] mask);
    @(posedge clk);
    #1;
    mem_addr  = addr;
    mem_wdata = data;
    mem_wmask = mask;
    @(posedge clk);
    #1;
    mem_wmask = '0;
  endtask

  // strobe for one cycle, address held one more, data taken at the next edge
  task automatic bus_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
    @(posedge clk);
    #1;
    mem_addr  = addr;
    mem_wmask = '0;
    mem_rstrb = 1'b1;
    @(posedge clk);
    #1;
    mem_rstrb = 1'b0;
    @(posedge clk);
    data = mem_rdata;
  endtask

  function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
                                                    input logic [DATA_W-1:0] new_word,
                                                    input logic [MASK_W-1:0] mask);
    logic [DATA_W-1:0] result;
    result = old_word;
    for (int b = 0; b < MASK_W; b++) begin
      if (mask[b]) begin
        result[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return result;
  endfunction

  task automatic run_op(input logic [7:0] op, input logic [DATA_W-1:0] addr,
                        input logic [DATA_W-1:0] data, input logic [DATA_W-1:0] mask,
                        input logic [DATA_W-1:0] expected);
    logic [DATA_W-1:0] rd;
    case (op)
      "W": bus_write(addr, data, mask[MASK_W-1:0]);
      "R": begin
        bus_read(addr, rd);
        check("mem_rdata", rd, expected);
      end
      // data field selects the status bits to wait on
      "P": begin
        do begin
          bus_read(addr, rd);
        end while ((rd & data) != expected);
      end
      "L": check("led", DATA_W'(led), expected);
      "D": repeat (data) @(posedge clk);
      default: begin
        $display("operation %0d has an unknown code '%c'", op_no, op);
        $display("TEST FAILED");
        $fatal(1, "bad test data");
      end
    endcase
  endtask

  initial begin
    int                fd;
    int                n;
    int                idx;
    logic              done;
    logic [7:0]        op;
    logic [DATA_W-1:0] f_addr;
    logic [DATA_W-1:0] f_data;
    logic [DATA_W-1:0] f_mask;
    logic [DATA_W-1:0] f_exp;
    logic [DATA_W-1:0] rd;
    logic [DATA_W-1:0] word;
    logic [MASK_W-1:0] mask;
    logic [8*256-1:0]  skip_line;

    clk       = 1'b0;
    rst_n     = 1'b0;
    mem_addr  = '0;
    mem_wdata = '0;
    mem_wmask = '0;
    mem_rstrb = 1'b0;
    cycle_cnt = 0;
    op_no     = 0;
    void'($urandom(SEED));

    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // serial line idles high
    check("txd", DATA_W'(txd), DATA_W'(1'b1));

    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) begin
      $display("cannot open the test data file %s", DATA_FILE);
      $display("TEST FAILED");
      $fatal(1, "missing test data");
    end

    done = 1'b0;
    while (!done) begin
      n = $fscanf(fd, " %c", op);
      if (n != 1) begin
        done = 1'b1;
      end else if (op == "#") begin
        n = $fgets(skip_line, fd);
      end else begin
        op_no++;
        n = $fscanf(fd, "%h %h %h %h", f_addr, f_data, f_mask, f_exp);
        if (n != 4) begin
          $display("operation %0d in the test data is missing fields", op_no);
          $display("TEST FAILED");
          $fatal(1, "bad test data");
        end
        run_op(op, f_addr, f_data, f_mask, f_exp);
      end
    end
    $fclose(fd);

    // random pass, full word first so no byte stays unknown
    for (int i = 0; i < RAND_WORDS; i++) begin
      op_no++;
      idx  = $urandom_range(RAM_WORDS - 1, 0);
      word = $urandom;
      bus_write(RAM_BASE + ADDR_W'(idx * 4), word, '1);
      model[idx] = word;
      word = $urandom;
      mask = MASK_W'($urandom_range((1 << MASK_W) - 1, 1));
      bus_write(RAM_BASE + ADDR_W'(idx * 4), word, mask);
      model[idx] = merge_bytes(model[idx], word, mask);
      rand_idx.push_back(idx);
    end
    foreach (rand_idx[i]) begin
      op_no++;
      bus_read(RAM_BASE + ADDR_W'(rand_idx[i] * 4), rd);
      check("mem_rdata", rd, model[rand_idx[i]]);
    end

    $display("TEST PASSED");
    $finish;
  end

endmodule

/* uart/peripheral_uart.sv */
module peripheral_uart
  import soc_map_pkg::*;
  import uart_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   cs,
  input  logic                   rd,
  input  logic                   wr,
  input  logic [UART_OFFS_W-1:0] addr,
  input  logic [DATA_W-1:0]      d_in,
  output logic [DATA_W-1:0]      d_out,
  output logic                   txd,
  input  logic                   rxd,
  output logic                   led
);

  logic              tx_start;
  logic              tx_busy;
  logic              rx_done;
  logic [7:0]        rx_byte;
  logic [7:0]        rx_data;
  logic              rx_valid;
  logic              reg_wr;
  logic              reg_rd;
  logic [DATA_W-1:0] status;

  assign reg_wr = cs & wr;
  assign reg_rd = cs & rd;

  // busy transmitter drops the write
  assign tx_start = reg_wr && (addr == UART_TXDATA) && !tx_busy;

  uart_tx_fsm u_tx (
    .clk     (clk),
    .rst_n   (rst_n),
    .tx_start(tx_start),
    .tx_byte (d_in[7:0]),
    .txd     (txd),
    .tx_busy (tx_busy)
  );

  uart_rx_fsm u_rx (
    .clk    (clk),
    .rst_n  (rst_n),
    .rxd    (rxd),
    .rx_done(rx_done),
    .rx_byte(rx_byte)
  );

  always_comb begin
    status = '0;
    status[ST_TX_BUSY]  = tx_busy;
    status[ST_RX_VALID] = rx_valid;
  end

  // newest byte wins, even over an unread one
  always_ff @(posedge clk) begin
    if (rx_done) begin
      rx_data <= rx_byte;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_valid <= 1'b0;
      led      <= 1'b0;
      d_out    <= '0;
    end else begin
      if (rx_done) begin
        rx_valid <= 1'b1;
      end else if (reg_rd && addr == UART_RXDATA) begin
        rx_valid <= 1'b0;
      end
      if (reg_wr && addr == UART_LED) begin
        led <= d_in[0];
      end
      if (reg_rd) begin
        case (addr)
          UART_STATUS: d_out <= status;
          UART_RXDATA: d_out <= {{(DATA_W-8){1'b0}}, rx_data};
          UART_LED:    d_out <= {{(DATA_W-1){1'b0}}, led};
          default:     d_out <= '0;
        endcase
      end
    end
  end

endmodule

/* uart/uart_baud_timer.sv */
module uart_baud_timer
  import uart_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic restart,
  input  logic half,
  output logic tick
);

  localparam logic [BAUD_CNT_W-1:0] FULL_LOAD = BAUD_CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [BAUD_CNT_W-1:0] HALF_LOAD = BAUD_CNT_W'(CLKS_PER_BIT / 2 - 1);

  logic [BAUD_CNT_W-1:0] cnt;

  assign tick = (cnt == '0);

  // reload on restart, otherwise count down and wrap each period
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= FULL_LOAD;
    end else if (restart) begin
      cnt <= half ? HALF_LOAD : FULL_LOAD;
    end else if (tick) begin
      cnt <= FULL_LOAD;
    end else begin
      cnt <= cnt - 1'b1;
    end
  end

  // owning FSM only restarts while idle, never on an expiring period
  a_no_tick_on_restart: assert property (
    @(posedge clk) disable iff (!rst_n) restart |-> !tick
  );

endmodule

/* uart/uart_rx_fsm.sv */
module uart_rx_fsm
  import uart_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rxd,
  output logic       rx_done,
  output logic [7:0] rx_byte
);

  rx_state_e  state;
  logic       rxd_meta;
  logic       rxd_s;
  logic       rxd_d;
  logic [2:0] bit_cnt;
  logic [7:0] shreg;
  logic       tick;

  // two-flop synchronizer plus one delay for edge detect
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rxd_meta <= 1'b1;
      rxd_s    <= 1'b1;
      rxd_d    <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_s    <= rxd_meta;
      rxd_d    <= rxd_s;
    end
  end

  // half period loaded while idle, so first tick lands mid start bit
  uart_baud_timer u_timer (
    .clk    (clk),
    .rst_n  (rst_n),
    .restart(state == RX_IDLE),
    .half   (1'b1),
    .tick   (tick)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= RX_IDLE;
      bit_cnt <= '0;
      rx_done <= 1'b0;
    end else begin
      rx_done <= 1'b0;
      case (state)
        RX_IDLE: begin
          if (rxd_d && !rxd_s) begin
            state <= RX_START;
          end
        end
        RX_START: begin
          if (tick) begin
            // line back high means a glitch, not a start bit
            state   <= rxd_s ? RX_IDLE : RX_DATA;
            bit_cnt <= '0;
          end
        end
        RX_DATA: begin
          if (tick) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) begin
              state <= RX_STOP;
            end
          end
        end
        RX_STOP: begin
          if (tick) begin
            state   <= RX_IDLE;
            rx_done <= rxd_s;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // data sampled at bit centre, lsb arrives first
  always_ff @(posedge clk) begin
    if (state == RX_DATA && tick) begin
      shreg <= {rxd_s, shreg[7:1]};
    end
  end

  assign rx_byte = shreg;

endmodule

/* uart/uart_tx_fsm.sv */
module uart_tx_fsm
  import uart_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tx_start,
  input  logic [7:0] tx_byte,
  output logic       txd,
  output logic       tx_busy
);

  tx_state_e  state;
  logic [7:0] shreg;
  logic [2:0] bit_cnt;
  logic       tick;

  // timer held in reload while idle
  uart_baud_timer u_timer (
    .clk    (clk),
    .rst_n  (rst_n),
    .restart(state == TX_IDLE),
    .half   (1'b0),
    .tick   (tick)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= TX_IDLE;
      txd     <= 1'b1;
      tx_busy <= 1'b0;
      bit_cnt <= '0;
    end else begin
      case (state)
        TX_IDLE: begin
          if (tx_start) begin
            state   <= TX_START;
            txd     <= 1'b0;
            tx_busy <= 1'b1;
            bit_cnt <= '0;
          end
        end
        TX_START: begin
          if (tick) begin
            state <= TX_DATA;
            txd   <= shreg[0];
          end
        end
        TX_DATA: begin
          if (tick) begin
            if (bit_cnt == 3'd7) begin
              state <= TX_STOP;
              txd   <= 1'b1;
            end else begin
              txd     <= shreg[0];
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
        end
        TX_STOP: begin
          if (tick) begin
            state   <= TX_IDLE;
            tx_busy <= 1'b0;
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  // lsb first, next bit always in shreg[0]
  always_ff @(posedge clk) begin
    if (state == TX_IDLE && tx_start) begin
      shreg <= tx_byte;
    end else if (tick && (state == TX_START || state == TX_DATA)) begin
      shreg <= {1'b0, shreg[7:1]};
    end
  end

  a_busy_tracks_state: assert property (
    @(posedge clk) disable iff (!rst_n) tx_busy == (state != TX_IDLE)
  );

endmodule

/* verilog/address_decoder.sv */
module address_decoder
  import soc_map_pkg::*;
(
  input  logic [ADDR_W-1:0] mem_addr,
  output logic [NUM_CS-1:0] cs
);

  logic ram_hit;
  logic uart_hit;

  // compare upper bits against each window base
  assign ram_hit =
    (mem_addr[ADDR_W-1:RAM_SEL_LSB] == RAM_BASE[ADDR_W-1:RAM_SEL_LSB]);
  assign uart_hit =
    (mem_addr[ADDR_W-1:UART_SEL_LSB] == UART_BASE[ADDR_W-1:UART_SEL_LSB]);

  always_comb begin
    cs = '0;
    cs[CS_RAM]  = ram_hit;
    cs[CS_UART] = uart_hit;
  end

  // windows must never overlap
  always_comb begin
    a_cs_onehot: assert ($onehot0(cs))
      else $error("address_decoder: overlapping selects %b", cs);
  end

endmodule

/* verilog/data_ram.sv */
module data_ram
  import soc_map_pkg::*;
(
  input  logic              clk,
  input  logic [ADDR_W-1:0] mem_addr,
  input  logic              mem_rstrb,
  input  logic [DATA_W-1:0] mem_wdata,
  input  logic [MASK_W-1:0] mem_wmask,
  output logic [DATA_W-1:0] mem_rdata
);

  logic [DATA_W-1:0] mem [RAM_WORDS];
  logic [RAM_AW-1:0] word_addr;

  // word index, byte offset dropped
  assign word_addr = mem_addr[RAM_AW+1:2];

  // byte lanes written by mask
  always_ff @(posedge clk) begin
    for (int b = 0; b < MASK_W; b++) begin
      if (mem_wmask[b]) begin
        mem[word_addr][8*b +: 8] <= mem_wdata[8*b +: 8];
      end
    end
  end

  // registered read port
  always_ff @(posedge clk) begin
    if (mem_rstrb) begin
      mem_rdata <= mem[word_addr];
    end
  end

endmodule

/* verilog/read_mux.sv */
module read_mux
  import soc_map_pkg::*;
(
  input  logic [NUM_CS-1:0] cs,
  input  logic [DATA_W-1:0] ram_rdata,
  input  logic [DATA_W-1:0] uart_rdata,
  output logic [DATA_W-1:0] mem_rdata
);

  // unmapped space reads as zero
  always_comb begin
    mem_rdata = '0;
    if (cs[CS_RAM]) begin
      mem_rdata = ram_rdata;
    end else if (cs[CS_UART]) begin
      mem_rdata = uart_rdata;
    end
  end

endmodule

/* verilog/soc_periph.sv */
module soc_periph
  import soc_map_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic [ADDR_W-1:0] mem_addr,
  input  logic [DATA_W-1:0] mem_wdata,
  input  logic [MASK_W-1:0] mem_wmask,
  input  logic              mem_rstrb,
  output logic [DATA_W-1:0] mem_rdata,
  output logic              txd,
  input  logic              rxd,
  output logic              led
);

  logic [NUM_CS-1:0] cs;
  logic [DATA_W-1:0] ram_rdata;
  logic [DATA_W-1:0] uart_rdata;
  logic              ram_rstrb;
  logic [MASK_W-1:0] ram_wmask;
  logic              uart_rd;
  logic              uart_wr;

  // strobes qualified by chip select
  assign ram_rstrb = cs[CS_RAM] & mem_rstrb;
  assign ram_wmask = {MASK_W{cs[CS_RAM]}} & mem_wmask;
  assign uart_rd   = cs[CS_UART] & mem_rstrb;
  assign uart_wr   = cs[CS_UART] & (|mem_wmask);

  address_decoder u_decoder (
    .mem_addr(mem_addr),
    .cs      (cs)
  );

  data_ram u_ram (
    .clk      (clk),
    .mem_addr (mem_addr),
    .mem_rstrb(ram_rstrb),
    .mem_wdata(mem_wdata),
    .mem_wmask(ram_wmask),
    .mem_rdata(ram_rdata)
  );

  peripheral_uart u_uart (
    .clk  (clk),
    .rst_n(rst_n),
    .cs   (cs[CS_UART]),
    .rd   (uart_rd),
    .wr   (uart_wr),
    .addr (mem_addr[UART_OFFS_W-1:0]),
    .d_in (mem_wdata),
    .d_out(uart_rdata),
    .txd  (txd),
    .rxd  (rxd),
    .led  (led)
  );

  read_mux u_read_mux (
    .cs        (cs),
    .ram_rdata (ram_rdata),
    .uart_rdata(uart_rdata),
    .mem_rdata (mem_rdata)
  );

endmodule
